//--- Makefile
# Verilator build and run for the receive subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_ds_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= All tests passed!

SOURCES := rtl/hpsdr_defs.svh \
           rtl/hpsdr_pkg.sv \
           rtl/sample_assembler.sv \
           rtl/cmd_regs.sv \
           rtl/ds_unpack.sv \
           rtl/ds_top.sv \
           bench/tb_clock.sv \
           bench/tb_ds_top.sv

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_clock.sv
// Free running bench clock; reset is released on a falling edge so stimulus never races it
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_ds_top.sv
// Directed bench for ds_top; expects whole packets with valid held high and bytes on falling edges
`timescale 1ns/10ps
`default_nettype none

`include "hpsdr_defs.svh"

module tb_ds_top;

  localparam int PKT_BYTES   = 1032;
  localparam int DATA_PKTS   = 9;
  localparam int PULSES      = `HPSDR_HANG_MS + 1024 + 1200;
  localparam int TEST_CYCLES = DATA_PKTS * PKT_BYTES + 2 * PULSES + 600;
  localparam int TIMEOUT_NS  = TEST_CYCLES * 100 + 200000;

  logic                    clk;
  logic                    arst_n;
  hpsdr_pkg::eth_byte_t    eth_in;
  logic                    watchdog_up;
  logic                    msec_pulse;
  logic                    flash_erase_ack;
  logic                    run;
  logic                    wide_spectrum;
  logic                    discovery;
  hpsdr_pkg::lr_sample_t   lr_out;
  logic                    lr_strobe;
  hpsdr_pkg::iq_sample_t   iq_out;
  logic                    iq_ptt;
  logic                    iq_strobe;
  hpsdr_pkg::radio_cfg_t   cfg;
  hpsdr_pkg::cmd_word_t    cmd_out;
  hpsdr_pkg::sample_beat_t flash_beat;
  logic [13:0]             flash_cnt;
  logic                    flash_erase;

  integer      seed;
  int          errors;
  int          mon_errors  = 0;
  int          disc_pulses = 0;
  int          lr_seen     = 0;
  int          iq_seen     = 0;
  logic [15:0] cur_port;
  logic [31:0] seq_num;
  logic [31:0] lr_exp[$];
  logic [31:0] iq_exp[$];
  logic [7:0]  flash_exp[$];

  // Reference model of the keyer enable and CW hang
  logic keyer_bit;
  int   hang_left;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  ds_top dut (
    .clk             (clk),
    .arst_n          (arst_n),
    .eth_in          (eth_in),
    .watchdog_up     (watchdog_up),
    .msec_pulse      (msec_pulse),
    .flash_erase_ack (flash_erase_ack),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .discovery       (discovery),
    .lr_out          (lr_out),
    .lr_strobe       (lr_strobe),
    .iq_out          (iq_out),
    .iq_ptt          (iq_ptt),
    .iq_strobe       (iq_strobe),
    .cfg             (cfg),
    .cmd_out         (cmd_out),
    .flash_beat      (flash_beat),
    .flash_cnt       (flash_cnt),
    .flash_erase     (flash_erase)
  );

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what, inout int count);
    if (actual !== expected) begin
      count++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Output monitor sampling registered outputs before they update
  always @(posedge clk) begin
    if (arst_n) begin
      if (discovery) disc_pulses++;
      if (lr_strobe) begin
        lr_seen++;
        if (lr_exp.size() == 0) begin
          mon_errors++;
          $display("L/R word came out at %0d ns with none expected", $time);
        end else begin
          check_value(64'(lr_out), 64'(lr_exp.pop_front()), "lr_out", mon_errors);
        end
      end
      if (iq_strobe) begin
        iq_seen++;
        if (iq_exp.size() == 0) begin
          mon_errors++;
          $display("I/Q word came out at %0d ns with none expected", $time);
        end else begin
          check_value(64'(iq_out), 64'(iq_exp.pop_front()), "iq_out", mon_errors);
        end
      end
      if (flash_beat.valid) begin
        if (flash_exp.size() == 0) begin
          mon_errors++;
          $display("Flash byte came out at %0d ns with none expected", $time);
        end else begin
          check_value(64'(flash_beat.last), 64'(flash_exp.size() == 1), "flash last", mon_errors);
          check_value(64'(flash_beat.data), 64'(flash_exp.pop_front()), "flash data", mon_errors);
        end
      end
    end
  end

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    eth_in.valid       = 1'b1;
    eth_in.broadcast   = 1'b0;
    eth_in.unreachable = 1'b0;
    eth_in.port        = cur_port;
    eth_in.data        = b;
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      eth_in.valid = 1'b0;
      eth_in.data  = 8'h00;
    end
  endtask

  task automatic send_header(input logic [7:0] pkt_type);
    send_byte(`HPSDR_PRE0);
    send_byte(`HPSDR_PRE1);
    send_byte(pkt_type);
  endtask

  task automatic send_run(input logic [7:0] b);
    send_header(`HPSDR_TYPE_RUN);
    send_byte(b);
    bus_idle(2);
  endtask

  task automatic send_discovery();
    send_header(`HPSDR_TYPE_DISC);
    send_byte(8'h00);
    bus_idle(2);
  endtask

  task automatic send_data_header();
    send_header(`HPSDR_TYPE_DATA);
    send_byte(8'h02);
    for (int k = 3; k >= 0; k--) send_byte(seq_num[8*k +: 8]);
    seq_num++;
  endtask

  // One frame that ends early after the L/R bytes of cut_block
  task automatic send_frame(input logic ptt, input logic [5:0] addr, input logic [31:0] data,
                            input int cw_block, input int cut_block);
    logic [31:0] lr;
    logic [31:0] iq;
    logic        gate;
    repeat (3) send_byte(`HPSDR_SYNC);
    send_byte({1'b0, addr, ptt});
    for (int k = 3; k >= 0; k--) send_byte(data[8*k +: 8]);
    if (addr == `HPSDR_CWX_ADDR) keyer_bit = data[24];
    for (int blk = 0; blk < `HPSDR_BLOCKS; blk++) begin
      lr = $random(seed);
      iq = $random(seed);
      // CW flag is bit 0 of the second I/Q byte
      iq[16] = (blk == cw_block);
      for (int k = 3; k >= 0; k--) send_byte(lr[8*k +: 8]);
      lr_exp.push_back(lr);
      if (blk == cut_block) break;
      gate = ptt || (hang_left != 0);
      for (int k = 3; k >= 0; k--) send_byte(iq[8*k +: 8]);
      if (gate) iq_exp.push_back(iq);
      if (iq[16] && !ptt && keyer_bit) hang_left = `HPSDR_HANG_MS;
    end
  endtask

  task automatic send_data_packet(input logic ptt, input logic [5:0] addr0,
                                  input logic [31:0] data0, input logic [5:0] addr1,
                                  input logic [31:0] data1, input int cw_block);
    send_data_header();
    send_frame(ptt, addr0, data0, cw_block, -1);
    send_frame(ptt, addr1, data1, -1, -1);
    bus_idle(2);
  endtask

  task automatic pulse_msec(input int n);
    repeat (n) begin
      @(negedge clk);
      msec_pulse = 1'b1;
      @(negedge clk);
      msec_pulse = 1'b0;
      if (hang_left > 0) hang_left--;
    end
  endtask

  task automatic pulse_watchdog(input int n);
    repeat (n) begin
      @(negedge clk);
      watchdog_up = 1'b1;
      @(negedge clk);
      watchdog_up = 1'b0;
    end
  endtask

  task automatic check_word_counts(input int lr0, input int iq0, input int lr_n, input int iq_n);
    check_value(64'(lr_seen - lr0), 64'(lr_n), "L/R word count", errors);
    check_value(64'(iq_seen - iq0), 64'(iq_n), "I/Q word count", errors);
    check_value(64'(lr_exp.size()), 64'd0, "pending L/R words", errors);
    check_value(64'(iq_exp.size()), 64'd0, "pending I/Q words", errors);
  endtask

  task automatic test_run_and_discovery();
    int d0;
    send_run(8'h03);
    check_value(64'({run, wide_spectrum}), 64'd3, "run/wide after 0x03", errors);
    send_run(8'h02);
    check_value(64'({run, wide_spectrum}), 64'd1, "run/wide after 0x02", errors);
    send_run(8'h01);
    check_value(64'({run, wide_spectrum}), 64'd2, "run/wide after 0x01", errors);
    d0 = disc_pulses;
    send_discovery();
    check_value(64'(disc_pulses - d0), 64'd1, "discovery pulses", errors);
    // Other port must be ignored
    cur_port = `HPSDR_PORT + 16'd1;
    send_run(8'h02);
    send_discovery();
    cur_port = `HPSDR_PORT;
    check_value(64'({run, wide_spectrum}), 64'd2, "run/wide after foreign port", errors);
    check_value(64'(disc_pulses - d0), 64'd1, "discovery pulses after foreign port", errors);
    send_run(8'h00);
    check_value(64'({run, wide_spectrum}), 64'd0, "run/wide after 0x00", errors);
  endtask

  task automatic test_data_ptt();
    int lr0;
    int iq0;
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b1, 6'h01, 32'h0a1b2c3d, 6'h02, 32'h01d4c0aa, -1);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 2 * `HPSDR_BLOCKS);
    check_value(64'(cmd_out), 64'({1'b0, 6'h02, 1'b1, 32'h01d4c0aa}), "cmd_out", errors);
    check_value(64'(iq_ptt), 64'd1, "iq_ptt", errors);
    check_value(64'(cfg.tx_freq), 64'h0a1b2c3d, "tx_freq", errors);
    check_value(64'(cfg.rx_freq), 64'h01d4c0aa, "rx_freq", errors);
    check_value(64'(cfg.config_word), 64'd0, "config", errors);
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b1, 6'h00, 32'h00000f18, 6'h05, 32'h12345678, -1);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 2 * `HPSDR_BLOCKS);
    check_value(64'(cmd_out), 64'({1'b0, 6'h05, 1'b1, 32'h12345678}), "cmd_out", errors);
    check_value(64'(cfg.config_word), 64'h00000f18, "config", errors);
    check_value(64'(cfg.tx_freq), 64'h0a1b2c3d, "tx_freq kept", errors);
    check_value(64'(cfg.rx_freq), 64'h01d4c0aa, "rx_freq kept", errors);
  endtask

  task automatic test_cw_hang();
    int lr0;
    int iq0;
    lr0 = lr_seen;
    iq0 = iq_seen;
    // CW flag without the keyer bit leaves I/Q off
    send_data_packet(1'b0, 6'h03, 32'h0, 6'h03, 32'h0, 0);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 0);
    check_value(64'(iq_ptt), 64'd0, "iq_ptt", errors);
    // Keyer bit and CW in block 0; I/Q flows from block 1
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b0, `HPSDR_CWX_ADDR, 32'h01000000, 6'h03, 32'h0, 0);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 2 * `HPSDR_BLOCKS - 1);
    pulse_msec(`HPSDR_HANG_MS - 1);
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b0, 6'h03, 32'h0, 6'h03, 32'h0, -1);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 2 * `HPSDR_BLOCKS);
    pulse_msec(1);
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b0, 6'h03, 32'h0, 6'h03, 32'h0, -1);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 0);
  endtask

  task automatic test_packet_watchdog();
    send_run(8'h03);
    pulse_watchdog(1000);
    check_value(64'({run, wide_spectrum}), 64'd3, "run/wide before watchdog expiry", errors);
    pulse_watchdog(24);
    check_value(64'({run, wide_spectrum}), 64'd0, "run/wide after 1024 watchdog pulses",
                errors);
    send_run(8'h01);
    pulse_watchdog(600);
    send_data_packet(1'b1, 6'h03, 32'h0, 6'h03, 32'h0, -1);
    pulse_watchdog(600);
    check_value(64'(run), 64'd1, "run kept by data packet", errors);
    send_run(8'h00);
  endtask

  task automatic test_flash();
    logic [31:0] count;
    logic [7:0]  b;
    count = 32'hffffea5c;
    send_header(`HPSDR_TYPE_FLASH);
    send_byte(8'h01);
    for (int k = 3; k >= 0; k--) send_byte(count[8*k +: 8]);
    for (int n = 0; n < 256; n++) begin
      b = 8'($random(seed));
      flash_exp.push_back(b);
      send_byte(b);
    end
    bus_idle(2);
    check_value(64'(flash_exp.size()), 64'd0, "pending flash bytes", errors);
    check_value(64'(flash_cnt), 64'(count[13:0]), "flash_cnt", errors);
    send_header(`HPSDR_TYPE_FLASH);
    send_byte(8'h02);
    bus_idle(5);
    check_value(64'(flash_erase), 64'd1, "flash_erase held", errors);
    bus_idle(20);
    check_value(64'(flash_erase), 64'd1, "flash_erase still held", errors);
    @(negedge clk);
    flash_erase_ack = 1'b1;
    @(negedge clk);
    flash_erase_ack = 1'b0;
    check_value(64'(flash_erase), 64'd0, "flash_erase after ack", errors);
  endtask

  task automatic test_valid_drop();
    int lr0;
    int iq0;
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_header();
    send_frame(1'b1, 6'h03, 32'h0, -1, 10);
    bus_idle(2);
    repeat (8) begin
      @(posedge clk);
      if (lr_strobe || iq_strobe || flash_beat.valid || discovery) begin
        errors++;
        $display("Output strobe seen at %0d ns while the byte stream was stopped", $time);
      end
    end
    check_word_counts(lr0, iq0, 11, 10);
    lr0 = lr_seen;
    iq0 = iq_seen;
    send_data_packet(1'b1, 6'h03, 32'h0, 6'h03, 32'h0, -1);
    check_word_counts(lr0, iq0, 2 * `HPSDR_BLOCKS, 2 * `HPSDR_BLOCKS);
  endtask

  initial begin
    int total;
    seed            = 32'hecc8;
    errors          = 0;
    eth_in          = '0;
    watchdog_up     = 1'b0;
    msec_pulse      = 1'b0;
    flash_erase_ack = 1'b0;
    cur_port        = `HPSDR_PORT;
    seq_num         = 32'd0;
    keyer_bit       = 1'b0;
    hang_left       = 0;
    @(posedge arst_n);
    bus_idle(2);
    test_run_and_discovery();
    test_data_ptt();
    test_cw_hang();
    test_packet_watchdog();
    test_flash();
    test_valid_drop();
    bus_idle(4);
    total = errors + mon_errors;
    $display("Errors: %0d in test checks, %0d in output monitor, %0d total",
             errors, mon_errors, total);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Run time limit from the total packet bytes and pulse cycles
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/hpsdr_pkg.sv
rtl/sample_assembler.sv
rtl/cmd_regs.sv
rtl/ds_unpack.sv
rtl/ds_top.sv
bench/tb_clock.sv
bench/tb_ds_top.sv

//--- rtl/cmd_regs.sv
// Configuration registers written from command words; addresses other than 0 to 2 are ignored
`timescale 1ns/10ps
`default_nettype none

module cmd_regs (
  input  wire                    clk,
  input  wire                    arst_n,
  input  hpsdr_pkg::cmd_word_t   cmd,
  input  wire                    cmd_toggle,
  output hpsdr_pkg::radio_cfg_t  cfg
);

  localparam logic [5:0] ADDR_CONFIG  = 6'h00;
  localparam logic [5:0] ADDR_TX_FREQ = 6'h01;
  localparam logic [5:0] ADDR_RX_FREQ = 6'h02;

  logic toggle_q;
  logic new_cmd;

  // Any edge of the toggle marks a finished command
  assign new_cmd = toggle_q ^ cmd_toggle;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      toggle_q <= 1'b0;
    end else begin
      toggle_q <= cmd_toggle;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg <= '0;
    end else if (new_cmd) begin
      case (cmd.addr)
        ADDR_CONFIG:  cfg.config_word <= cmd.data;
        ADDR_TX_FREQ: cfg.tx_freq <= cmd.data;
        ADDR_RX_FREQ: cfg.rx_freq <= cmd.data;
        default: ;
      endcase
    end
  end

  // Address is set on the control byte, well before the toggle moves
  a_addr_settled: assert property (@(posedge clk) disable iff (!arst_n)
    new_cmd |-> $stable(cmd.addr));

endmodule

`default_nettype wire

//--- rtl/ds_top.sv
// Receive subsystem top; no flow control so the byte source must never stall mid-packet
`timescale 1ns/10ps
`default_nettype none

module ds_top (
  input  wire                     clk,
  input  wire                     arst_n,
  input  hpsdr_pkg::eth_byte_t    eth_in,
  input  wire                     watchdog_up,
  input  wire                     msec_pulse,
  input  wire                     flash_erase_ack,
  output logic                    run,
  output logic                    wide_spectrum,
  output logic                    discovery,
  output hpsdr_pkg::lr_sample_t   lr_out,
  output logic                    lr_strobe,
  output hpsdr_pkg::iq_sample_t   iq_out,
  output logic                    iq_ptt,
  output logic                    iq_strobe,
  output hpsdr_pkg::radio_cfg_t   cfg,
  output hpsdr_pkg::cmd_word_t    cmd_out,
  output hpsdr_pkg::sample_beat_t flash_beat,
  output logic [13:0]             flash_cnt,
  output logic                    flash_erase
);

  hpsdr_pkg::sample_beat_t lr_beat;
  hpsdr_pkg::sample_beat_t iq_beat;
  logic                    cmd_toggle;

  ds_unpack u_unpack (
    .clk             (clk),
    .arst_n          (arst_n),
    .eth_in          (eth_in),
    .watchdog_up     (watchdog_up),
    .msec_pulse      (msec_pulse),
    .flash_erase_ack (flash_erase_ack),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .discovery       (discovery),
    .cmd             (cmd_out),
    .cmd_toggle      (cmd_toggle),
    .lr_beat         (lr_beat),
    .iq_beat         (iq_beat),
    .flash_beat      (flash_beat),
    .iq_ptt          (iq_ptt),
    .flash_cnt       (flash_cnt),
    .flash_erase     (flash_erase)
  );

  // Audio pairs toward the codec
  sample_assembler #(.payload_t(hpsdr_pkg::lr_sample_t)) u_lr_asm (
    .clk    (clk),
    .arst_n (arst_n),
    .beat   (lr_beat),
    .word   (lr_out),
    .strobe (lr_strobe)
  );

  sample_assembler #(.payload_t(hpsdr_pkg::iq_sample_t)) u_iq_asm (
    .clk    (clk),
    .arst_n (arst_n),
    .beat   (iq_beat),
    .word   (iq_out),
    .strobe (iq_strobe)
  );

  cmd_regs u_cmd_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd        (cmd_out),
    .cmd_toggle (cmd_toggle),
    .cfg        (cfg)
  );

endmodule

`default_nettype wire

//--- rtl/ds_unpack.sv
// Byte-per-cycle packet parser with no back-pressure; valid must stay high for a whole packet
`timescale 1ns/10ps
`default_nettype none

`include "hpsdr_defs.svh"

module ds_unpack (
  input  wire                     clk,
  input  wire                     arst_n,
  input  hpsdr_pkg::eth_byte_t    eth_in,
  input  wire                     watchdog_up,
  input  wire                     msec_pulse,
  input  wire                     flash_erase_ack,
  output logic                    run,
  output logic                    wide_spectrum,
  output logic                    discovery,
  output hpsdr_pkg::cmd_word_t    cmd,
  output logic                    cmd_toggle,
  output hpsdr_pkg::sample_beat_t lr_beat,
  output hpsdr_pkg::sample_beat_t iq_beat,
  output hpsdr_pkg::sample_beat_t flash_beat,
  output logic                    iq_ptt,
  output logic [13:0]             flash_cnt,
  output logic                    flash_erase
);

  localparam int HANG_W = $clog2(`HPSDR_HANG_MS + 1);

  typedef enum logic [5:0] {
    ST_IDLE      = 6'h00,
    ST_PRE       = 6'h01,
    ST_TYPE      = 6'h02,
    ST_RUNSTOP   = 6'h03,
    ST_DISC      = 6'h04,
    ST_ENDPOINT  = 6'h05,
    ST_SEQ3      = 6'h06,
    ST_SEQ2      = 6'h07,
    ST_SEQ1      = 6'h08,
    ST_SEQ0      = 6'h09,
    ST_SYNC2     = 6'h10,
    ST_SYNC1     = 6'h11,
    ST_SYNC0     = 6'h12,
    ST_CMDCTRL   = 6'h13,
    ST_CMD3      = 6'h14,
    ST_CMD2      = 6'h15,
    ST_CMD1      = 6'h16,
    ST_CMD0      = 6'h17,
    ST_PUSHL1    = 6'h18,
    ST_PUSHL0    = 6'h19,
    ST_PUSHR1    = 6'h1a,
    ST_PUSHR0    = 6'h1b,
    ST_PUSHI1    = 6'h1c,
    ST_PUSHI0    = 6'h1d,
    ST_PUSHQ1    = 6'h1e,
    ST_PUSHQ0    = 6'h1f,
    ST_FL_DECODE = 6'h20,
    ST_FL_CNT3   = 6'h21,
    ST_FL_CNT2   = 6'h22,
    ST_FL_CNT1   = 6'h23,
    ST_FL_CNT0   = 6'h24,
    ST_FL_PROG   = 6'h25,
    ST_FL_ERASE  = 6'h26
  } state_t;

  state_t state;
  state_t state_next;

  // Flash byte count or block count within a frame
  logic [7:0] cnt;

  logic [`HPSDR_WDOG_BITS-1:0] wdog_cnt;
  logic                        wdog_clr;

  logic [HANG_W-1:0] hang_cnt;
  logic              hang_load;
  logic              cw_bit;
  logic              cwx_en;
  logic              iq_gate;

  logic lr_v;
  logic lr_l;
  logic iq_v;
  logic iq_l;
  logic fl_v;
  logic fl_l;

  always_comb begin
    state_next = ST_IDLE;
    discovery  = 1'b0;
    wdog_clr   = 1'b0;
    lr_v       = 1'b0;
    lr_l       = 1'b0;
    iq_v       = 1'b0;
    iq_l       = 1'b0;
    fl_v       = 1'b0;
    fl_l       = 1'b0;
    case (state)
      ST_IDLE: begin
        if (eth_in.data == `HPSDR_PRE0 && eth_in.port == `HPSDR_PORT) state_next = ST_PRE;
      end
      ST_PRE: begin
        if (eth_in.data == `HPSDR_PRE1 && eth_in.port == `HPSDR_PORT) state_next = ST_TYPE;
      end
      ST_TYPE: begin
        case (eth_in.data)
          `HPSDR_TYPE_DATA:  state_next = ST_ENDPOINT;
          `HPSDR_TYPE_DISC:  state_next = ST_DISC;
          `HPSDR_TYPE_FLASH: state_next = ST_FL_DECODE;
          `HPSDR_TYPE_RUN:   state_next = ST_RUNSTOP;
          default:           state_next = ST_IDLE;
        endcase
      end
      ST_RUNSTOP: state_next = ST_IDLE;
      ST_DISC: discovery = 1'b1;
      ST_FL_DECODE: begin
        if (eth_in.data == 8'h01) state_next = ST_FL_CNT3;
        else if (eth_in.data == 8'h02) state_next = ST_FL_ERASE;
      end
      ST_FL_CNT3: state_next = ST_FL_CNT2;
      ST_FL_CNT2: state_next = ST_FL_CNT1;
      ST_FL_CNT1: state_next = ST_FL_CNT0;
      ST_FL_CNT0: state_next = ST_FL_PROG;
      ST_FL_PROG: begin
        fl_v = 1'b1;
        if (cnt == 8'hff) fl_l = 1'b1;
        else state_next = ST_FL_PROG;
      end
      ST_FL_ERASE: begin
        if (!flash_erase_ack) state_next = ST_FL_ERASE;
      end
      ST_ENDPOINT: begin
        if (eth_in.data == 8'h02) state_next = ST_SEQ3;
      end
      ST_SEQ3: state_next = ST_SEQ2;
      ST_SEQ2: state_next = ST_SEQ1;
      ST_SEQ1: state_next = ST_SEQ0;
      ST_SEQ0: begin
        // Host is alive once a data header arrives
        wdog_clr   = eth_in.valid;
        state_next = ST_SYNC2;
      end
      ST_SYNC2: if (eth_in.data == `HPSDR_SYNC) state_next = ST_SYNC1;
      ST_SYNC1: if (eth_in.data == `HPSDR_SYNC) state_next = ST_SYNC0;
      ST_SYNC0: if (eth_in.data == `HPSDR_SYNC) state_next = ST_CMDCTRL;
      ST_CMDCTRL: state_next = ST_CMD3;
      ST_CMD3: state_next = ST_CMD2;
      ST_CMD2: state_next = ST_CMD1;
      ST_CMD1: state_next = ST_CMD0;
      ST_CMD0: state_next = ST_PUSHL1;
      ST_PUSHL1: begin
        lr_v       = 1'b1;
        state_next = ST_PUSHL0;
      end
      ST_PUSHL0: begin
        lr_v       = 1'b1;
        state_next = ST_PUSHR1;
      end
      ST_PUSHR1: begin
        lr_v       = 1'b1;
        state_next = ST_PUSHR0;
      end
      ST_PUSHR0: begin
        lr_v       = 1'b1;
        lr_l       = 1'b1;
        state_next = ST_PUSHI1;
      end
      ST_PUSHI1: begin
        iq_v       = iq_gate;
        state_next = ST_PUSHI0;
      end
      ST_PUSHI0: begin
        iq_v       = iq_gate;
        state_next = ST_PUSHQ1;
      end
      ST_PUSHQ1: begin
        iq_v       = iq_gate;
        state_next = ST_PUSHQ0;
      end
      ST_PUSHQ0: begin
        iq_v = iq_gate;
        iq_l = iq_gate;
        // cnt was bumped on the L/R last byte of this block
        if (cnt == 8'(`HPSDR_BLOCKS)) state_next = ST_SYNC2;
        else state_next = ST_PUSHL1;
      end
      default: state_next = ST_IDLE;
    endcase
  end

  // Beats carry the live byte and vanish as soon as valid drops
  assign lr_beat    = '{data: eth_in.data, valid: lr_v & eth_in.valid, last: lr_l & eth_in.valid};
  assign iq_beat    = '{data: eth_in.data, valid: iq_v & eth_in.valid, last: iq_l & eth_in.valid};
  assign flash_beat = '{data: eth_in.data, valid: fl_v & eth_in.valid, last: fl_l & eth_in.valid};

  assign flash_erase = (state == ST_FL_ERASE);
  assign iq_ptt      = cmd.ptt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= ST_IDLE;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (eth_in.unreachable || &wdog_cnt) begin
      state         <= ST_IDLE;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (!eth_in.valid && state != ST_FL_ERASE) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
      if (state == ST_RUNSTOP) begin
        run           <= eth_in.data[0];
        wide_spectrum <= eth_in.data[1];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt        <= '0;
      cmd        <= '0;
      cmd_toggle <= 1'b0;
      flash_cnt  <= '0;
      cw_bit     <= 1'b0;
      cwx_en     <= 1'b0;
      iq_gate    <= 1'b0;
    end else if (eth_in.valid) begin
      case (state)
        ST_FL_DECODE, ST_SYNC2, ST_SYNC1, ST_SYNC0: cnt <= '0;
        ST_FL_CNT1: flash_cnt[13:8] <= eth_in.data[5:0];
        ST_FL_CNT0: flash_cnt[7:0] <= eth_in.data;
        ST_FL_PROG: cnt <= cnt + 8'd1;
        ST_CMDCTRL: begin
          cmd.resprqst <= eth_in.data[7];
          cmd.addr     <= eth_in.data[6:1];
          cmd.ptt      <= eth_in.data[0];
        end
        ST_CMD3: cmd.data[31:24] <= eth_in.data;
        ST_CMD2: cmd.data[23:16] <= eth_in.data;
        ST_CMD1: cmd.data[15:8] <= eth_in.data;
        ST_CMD0: begin
          cmd.data[7:0] <= eth_in.data;
          cmd_toggle    <= ~cmd_toggle;
          // Keyer internal bit sits in the top data byte
          if (cmd.addr == `HPSDR_CWX_ADDR) cwx_en <= cmd.data[24];
        end
        ST_PUSHR0: begin
          cnt     <= cnt + 8'd1;
          // Decide once per block so I/Q never comes out partial
          iq_gate <= cmd.ptt || (hang_cnt != '0);
        end
        ST_PUSHI0: cw_bit <= eth_in.data[0];
        default: ;
      endcase
    end
  end

  assign hang_load = eth_in.valid && (state == ST_PUSHQ0) && cw_bit && !cmd.ptt && cwx_en;

  // CW spacing hang
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hang_cnt <= '0;
    end else if (hang_load) begin
      hang_cnt <= HANG_W'(`HPSDR_HANG_MS);
    end else if (msec_pulse && hang_cnt != '0) begin
      hang_cnt <= hang_cnt - 1'b1;
    end
  end

  // Stop run if upstream keeps sending with no data packets coming back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wdog_cnt <= '0;
    end else if (!run || wdog_clr) begin
      wdog_cnt <= '0;
    end else if (watchdog_up) begin
      wdog_cnt <= wdog_cnt + 1'b1;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
    state inside {ST_IDLE, ST_PRE, ST_TYPE, ST_RUNSTOP, ST_DISC, ST_ENDPOINT,
                  ST_SEQ3, ST_SEQ2, ST_SEQ1, ST_SEQ0, ST_SYNC2, ST_SYNC1, ST_SYNC0,
                  ST_CMDCTRL, ST_CMD3, ST_CMD2, ST_CMD1, ST_CMD0,
                  ST_PUSHL1, ST_PUSHL0, ST_PUSHR1, ST_PUSHR0,
                  ST_PUSHI1, ST_PUSHI0, ST_PUSHQ1, ST_PUSHQ0,
                  ST_FL_DECODE, ST_FL_CNT3, ST_FL_CNT2, ST_FL_CNT1, ST_FL_CNT0,
                  ST_FL_PROG, ST_FL_ERASE});

  a_no_beat_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !eth_in.valid |-> !(lr_beat.valid || iq_beat.valid || flash_beat.valid));

  // Erase can only start from a flash request, never from inside a data frame
  a_erase_source: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(flash_erase) |-> $past(state) == ST_FL_DECODE);

endmodule

`default_nettype wire

//--- rtl/hpsdr_defs.svh
// Protocol constants for the card; type codes and sync values follow the HPSDR PC-to-card format
`ifndef HPSDR_DEFS_SVH
`define HPSDR_DEFS_SVH

// UDP port that the card listens on
`define HPSDR_PORT 16'd1024

// Packet preamble and frame sync
`define HPSDR_PRE0 8'hef
`define HPSDR_PRE1 8'hfe
`define HPSDR_SYNC 8'h7f

// Packet type byte after the preamble
`define HPSDR_TYPE_DATA  8'h01
`define HPSDR_TYPE_DISC  8'h02
`define HPSDR_TYPE_FLASH 8'h03
`define HPSDR_TYPE_RUN   8'h04

`define HPSDR_WDOG_BITS 10

// CW hang length in msec pulses
`define HPSDR_HANG_MS 500

// Sample blocks per frame
`define HPSDR_BLOCKS 63

// Command address holding the internal keyer bit
`define HPSDR_CWX_ADDR 6'h0f

`endif

//--- rtl/hpsdr_pkg.sv
// Shared packed types for the receive path; field order sets the bit layout seen by the bench
`default_nettype none

package hpsdr_pkg;

  // One byte from the UDP front end
  typedef struct packed {
    logic        valid;
    logic        broadcast;
    logic        unreachable;
    logic [15:0] port;
    logic [7:0]  data;
  } eth_byte_t;

  typedef struct packed {
    logic        resprqst;
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
  } cmd_word_t;

  typedef struct packed {
    logic [15:0] left;
    logic [15:0] right;
  } lr_sample_t;

  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_sample_t;

  // Byte strobe toward an assembler or the flash
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       last;
  } sample_beat_t;

  // Configuration words kept from host commands
  typedef struct packed {
    logic [31:0] tx_freq;
    logic [31:0] rx_freq;
    logic [31:0] config_word;
  } radio_cfg_t;

endpackage

`default_nettype wire

//--- rtl/sample_assembler.sv
// Packs strobed bytes MSB first into payload_t; payload width must be a whole number of bytes
`timescale 1ns/10ps
`default_nettype none

module sample_assembler #(
  parameter type payload_t = logic [31:0]
) (
  input  wire                     clk,
  input  wire                     arst_n,
  input  hpsdr_pkg::sample_beat_t beat,
  output payload_t                word,
  output logic                    strobe
);

  localparam int W     = $bits(payload_t);
  localparam int NB    = W / 8;
  localparam int CNT_W = (NB > 1) ? $clog2(NB) : 1;

  logic [W-1:0]     shreg;
  logic [CNT_W-1:0] byte_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt <= '0;
      strobe   <= 1'b0;
    end else begin
      strobe <= beat.valid && beat.last;
      if (beat.valid) begin
        if (beat.last) byte_cnt <= '0;
        else byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // Oldest byte ends up in the top bits
  always_ff @(posedge clk) begin
    if (beat.valid) shreg <= (shreg << 8) | W'(beat.data);
  end

  assign word = payload_t'(shreg);

  a_last_on_fill: assert property (@(posedge clk) disable iff (!arst_n)
    beat.valid |-> (beat.last == (byte_cnt == CNT_W'(NB - 1))));

endmodule

`default_nettype wire
